// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // Data path and PC width
  localparam int XLEN       = 64;
  localparam int EXU_INFO_W = 15;

  // Group codes in bits 2..0 of the execute-info bus
  localparam logic [2:0] EXU_GRP_ALU = 3'b001;
  localparam logic [2:0] EXU_GRP_BJP = 3'b010;

  // ALU group, one-hot operation bits
  localparam int EXU_ALU_ADD    = 3;
  localparam int EXU_ALU_SUB    = 4;
  localparam int EXU_ALU_SLL    = 5;
  localparam int EXU_ALU_SLT    = 6;
  localparam int EXU_ALU_SLTU   = 7;
  localparam int EXU_ALU_XOR    = 8;
  localparam int EXU_ALU_SRL    = 9;
  localparam int EXU_ALU_SRA    = 10;
  localparam int EXU_ALU_OR     = 11;
  localparam int EXU_ALU_AND    = 12;
  localparam int EXU_ALU_LUI    = 13;
  localparam int EXU_ALU_EBREAK = 14;

  // Branch/jump group, bits 11..14 stay zero
  localparam int EXU_BJP_JAL  = 3;
  localparam int EXU_BJP_JALR = 4;
  localparam int EXU_BJP_BEQ  = 5;
  localparam int EXU_BJP_BNE  = 6;
  localparam int EXU_BJP_BLT  = 7;
  localparam int EXU_BJP_BGE  = 8;
  localparam int EXU_BJP_BLTU = 9;
  localparam int EXU_BJP_BGEU = 10;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

// File: hdl/rv_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
  input  wire logic [31:0]                          inst_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]         pc_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]         rs1_data_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]         rs2_data_i,
  output logic                                      rd_wr_en_o,
  output logic [4:0]                                rs1_idx_o,
  output logic [4:0]                                rs2_idx_o,
  output logic [4:0]                                rd_idx_o,
  output logic [rv_core_pkg::XLEN-1:0]              op1_o,
  output logic [rv_core_pkg::XLEN-1:0]              op2_o,
  output logic [rv_core_pkg::XLEN-1:0]              op1_jp_o,
  output logic [rv_core_pkg::XLEN-1:0]              op2_jp_o,
  output logic [rv_core_pkg::EXU_INFO_W-1:0]        exu_info_bus_o,
  output logic                                      invalid_inst_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  logic is_op, is_op_imm, is_load, is_store, is_branch;
  logic is_jal, is_jalr, is_lui, is_auipc, is_system;
  logic add, sub, sll, slt, sltu, xor_r, srl, sra, or_r, and_r;
  logic addi, slli, slti, sltiu, xori, srli, srai, ori, andi;
  logic beq, bne, blt, bge, bltu, bgeu, jalr, ebreak;
  logic alu_op, bjp_op;
  logic [rv_core_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [rv_core_pkg::EXU_INFO_W-1:0] alu_info, bjp_info;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  // RV64 shifts carry a 6-bit shamt, so only the top six bits qualify them
  assign funct6 = inst_i[31:26];

  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // Opcode classes
  assign is_op     = opcode == rv_core_pkg::OPC_OP;
  assign is_op_imm = opcode == rv_core_pkg::OPC_OP_IMM;
  assign is_load   = opcode == rv_core_pkg::OPC_LOAD;
  assign is_store  = opcode == rv_core_pkg::OPC_STORE;
  assign is_branch = opcode == rv_core_pkg::OPC_BRANCH;
  assign is_jal    = opcode == rv_core_pkg::OPC_JAL;
  assign is_jalr   = opcode == rv_core_pkg::OPC_JALR;
  assign is_lui    = opcode == rv_core_pkg::OPC_LUI;
  assign is_auipc  = opcode == rv_core_pkg::OPC_AUIPC;
  assign is_system = opcode == rv_core_pkg::OPC_SYSTEM;

  // Immediates
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // Register-register
  assign add   = is_op & (funct3 == 3'd0) & (funct7 == 7'h00);
  assign sub   = is_op & (funct3 == 3'd0) & (funct7 == 7'h20);
  assign sll   = is_op & (funct3 == 3'd1) & (funct7 == 7'h00);
  assign slt   = is_op & (funct3 == 3'd2) & (funct7 == 7'h00);
  assign sltu  = is_op & (funct3 == 3'd3) & (funct7 == 7'h00);
  assign xor_r = is_op & (funct3 == 3'd4) & (funct7 == 7'h00);
  assign srl   = is_op & (funct3 == 3'd5) & (funct7 == 7'h00);
  assign sra   = is_op & (funct3 == 3'd5) & (funct7 == 7'h20);
  assign or_r  = is_op & (funct3 == 3'd6) & (funct7 == 7'h00);
  assign and_r = is_op & (funct3 == 3'd7) & (funct7 == 7'h00);

  // Register-immediate
  assign addi  = is_op_imm & (funct3 == 3'd0);
  assign slli  = is_op_imm & (funct3 == 3'd1) & (funct6 == 6'h00);
  assign slti  = is_op_imm & (funct3 == 3'd2);
  assign sltiu = is_op_imm & (funct3 == 3'd3);
  assign xori  = is_op_imm & (funct3 == 3'd4);
  assign srli  = is_op_imm & (funct3 == 3'd5) & (funct6 == 6'h00);
  assign srai  = is_op_imm & (funct3 == 3'd5) & (funct6 == 6'h10);
  assign ori   = is_op_imm & (funct3 == 3'd6);
  assign andi  = is_op_imm & (funct3 == 3'd7);

  // Branches, jumps, system
  assign beq    = is_branch & (funct3 == 3'd0);
  assign bne    = is_branch & (funct3 == 3'd1);
  assign blt    = is_branch & (funct3 == 3'd4);
  assign bge    = is_branch & (funct3 == 3'd5);
  assign bltu   = is_branch & (funct3 == 3'd6);
  assign bgeu   = is_branch & (funct3 == 3'd7);
  assign jalr   = is_jalr & (funct3 == 3'd0);
  assign ebreak = is_system & (inst_i[31:7] == 25'h0002000);

  assign alu_op = add | sub | sll | slt | sltu | xor_r | srl | sra | or_r | and_r |
                  addi | slli | slti | sltiu | xori | srli | srai | ori | andi |
                  is_lui | is_auipc | ebreak;
  assign bjp_op = beq | bne | blt | bge | bltu | bgeu | is_jal | jalr;

  // Loads and stores land here too, there is no LSU behind this decoder
  assign invalid_inst_o = ~(alu_op | bjp_op);

  assign rd_wr_en_o = (rd_idx_o != 5'd0) & ((alu_op & ~ebreak) | is_jal | jalr);

  assign imm = ({64{is_op_imm | is_load | jalr}} & imm_i) |
               ({64{is_store}}             & imm_s) |
               ({64{is_branch}}            & imm_b) |
               ({64{is_jal}}               & imm_j) |
               ({64{is_lui | is_auipc}}    & imm_u);

  // Operand selection
  assign op1_o = ({64{is_op | is_op_imm | is_load | is_store | is_branch}} & rs1_data_i) |
                 ({64{is_auipc | is_jal | jalr}} & pc_i);
  assign op2_o = ({64{is_op | is_branch}} & rs2_data_i) |
                 ({64{is_op_imm | is_load | is_store | is_lui | is_auipc}} & imm) |
                 ({64{is_jal | jalr}} & 64'd4);

  // Jump target operands
  assign op1_jp_o = ({64{jalr}} & rs1_data_i) | ({64{is_branch | is_jal}} & pc_i);
  assign op2_jp_o = {64{is_branch | is_jal | jalr}} & imm;

  always_comb begin
    alu_info = '0;
    alu_info[2:0] = rv_core_pkg::EXU_GRP_ALU;
    alu_info[rv_core_pkg::EXU_ALU_ADD]    = add | addi | is_auipc;
    alu_info[rv_core_pkg::EXU_ALU_SUB]    = sub;
    alu_info[rv_core_pkg::EXU_ALU_SLL]    = sll | slli;
    alu_info[rv_core_pkg::EXU_ALU_SLT]    = slt | slti;
    alu_info[rv_core_pkg::EXU_ALU_SLTU]   = sltu | sltiu;
    alu_info[rv_core_pkg::EXU_ALU_XOR]    = xor_r | xori;
    alu_info[rv_core_pkg::EXU_ALU_SRL]    = srl | srli;
    alu_info[rv_core_pkg::EXU_ALU_SRA]    = sra | srai;
    alu_info[rv_core_pkg::EXU_ALU_OR]     = or_r | ori;
    alu_info[rv_core_pkg::EXU_ALU_AND]    = and_r | andi;
    alu_info[rv_core_pkg::EXU_ALU_LUI]    = is_lui;
    alu_info[rv_core_pkg::EXU_ALU_EBREAK] = ebreak;
  end

  always_comb begin
    bjp_info = '0;
    bjp_info[2:0] = rv_core_pkg::EXU_GRP_BJP;
    bjp_info[rv_core_pkg::EXU_BJP_JAL]  = is_jal;
    bjp_info[rv_core_pkg::EXU_BJP_JALR] = jalr;
    bjp_info[rv_core_pkg::EXU_BJP_BEQ]  = beq;
    bjp_info[rv_core_pkg::EXU_BJP_BNE]  = bne;
    bjp_info[rv_core_pkg::EXU_BJP_BLT]  = blt;
    bjp_info[rv_core_pkg::EXU_BJP_BGE]  = bge;
    bjp_info[rv_core_pkg::EXU_BJP_BLTU] = bltu;
    bjp_info[rv_core_pkg::EXU_BJP_BGEU] = bgeu;
  end

  // Zero bus for anything invalid
  assign exu_info_bus_o = ({rv_core_pkg::EXU_INFO_W{alu_op}} & alu_info) |
                          ({rv_core_pkg::EXU_INFO_W{bjp_op}} & bjp_info);

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic [4:0]                    rs1_idx_i,
  input  wire logic [4:0]                    rs2_idx_i,
  output logic [rv_core_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_core_pkg::XLEN-1:0]       rs2_data_o,
  input  wire logic                          wr_en_i,
  input  wire logic [4:0]                    wr_idx_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]  wr_data_i
);

  // x1..x31, x0 has no storage
  logic [rv_core_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != 5'd0)) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Asynchronous reads
  assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire logic [rv_core_pkg::EXU_INFO_W-1:0]  info_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op1_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op2_i,
  output logic [rv_core_pkg::XLEN-1:0]             result_o
);

  logic [5:0] shamt;
  logic [rv_core_pkg::XLEN-1:0] add_res, sub_res, sll_res, srl_res, sra_res;
  logic [rv_core_pkg::XLEN-1:0] slt_res, sltu_res;

  assign shamt    = op2_i[5:0];
  assign add_res  = op1_i + op2_i;
  assign sub_res  = op1_i - op2_i;
  assign sll_res  = op1_i << shamt;
  assign srl_res  = op1_i >> shamt;
  assign sra_res  = $signed(op1_i) >>> shamt;
  assign slt_res  = {63'd0, $signed(op1_i) < $signed(op2_i)};
  assign sltu_res = {63'd0, op1_i < op2_i};

  // One-hot select; EBREAK has no term and yields zero
  always_comb begin
    result_o = ({64{info_i[rv_core_pkg::EXU_ALU_ADD]}}  & add_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_SUB]}}  & sub_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_SLL]}}  & sll_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_SLT]}}  & slt_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_SLTU]}} & sltu_res) |
               ({64{info_i[rv_core_pkg::EXU_ALU_XOR]}}  & (op1_i ^ op2_i)) |
               ({64{info_i[rv_core_pkg::EXU_ALU_SRL]}}  & srl_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_SRA]}}  & sra_res)  |
               ({64{info_i[rv_core_pkg::EXU_ALU_OR]}}   & (op1_i | op2_i)) |
               ({64{info_i[rv_core_pkg::EXU_ALU_AND]}}  & (op1_i & op2_i)) |
               ({64{info_i[rv_core_pkg::EXU_ALU_LUI]}}  & op2_i);
  end

endmodule

`default_nettype wire

// File: hdl/rv_bju.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bju (
  input  wire logic [rv_core_pkg::EXU_INFO_W-1:0]  info_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        rs1_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        rs2_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op1_jp_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op2_jp_i,
  output logic                                     taken_o,
  output logic [rv_core_pkg::XLEN-1:0]             target_o
);

  logic eq, lt_s, lt_u;
  logic [rv_core_pkg::XLEN-1:0] sum;

  // Comparisons
  assign eq   = rs1_i == rs2_i;
  assign lt_s = $signed(rs1_i) < $signed(rs2_i);
  assign lt_u = rs1_i < rs2_i;

  assign taken_o = info_i[rv_core_pkg::EXU_BJP_JAL]                |
                   info_i[rv_core_pkg::EXU_BJP_JALR]               |
                   (info_i[rv_core_pkg::EXU_BJP_BEQ]  & eq)        |
                   (info_i[rv_core_pkg::EXU_BJP_BNE]  & ~eq)       |
                   (info_i[rv_core_pkg::EXU_BJP_BLT]  & lt_s)      |
                   (info_i[rv_core_pkg::EXU_BJP_BGE]  & ~lt_s)     |
                   (info_i[rv_core_pkg::EXU_BJP_BLTU] & lt_u)      |
                   (info_i[rv_core_pkg::EXU_BJP_BGEU] & ~lt_u);

  // PC+imm for branches and JAL, rs1+imm for JALR
  assign sum = op1_jp_i + op2_jp_i;

  // JALR drops bit 0 of the sum
  assign target_o = {sum[rv_core_pkg::XLEN-1:1],
                     sum[0] & ~info_i[rv_core_pkg::EXU_BJP_JALR]};

endmodule

`default_nettype wire

// File: hdl/rv_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
  input  wire logic [rv_core_pkg::EXU_INFO_W-1:0]  exu_info_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op1_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op2_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        rs1_data_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        rs2_data_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op1_jp_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]        op2_jp_i,
  output logic [rv_core_pkg::XLEN-1:0]             wb_data_o,
  output logic                                     taken_o,
  output logic [rv_core_pkg::XLEN-1:0]             target_o,
  output logic                                     ebreak_o
);

  logic is_alu, is_bjp, bju_taken;
  logic [rv_core_pkg::EXU_INFO_W-1:0] alu_info, bjp_info;
  logic [rv_core_pkg::XLEN-1:0] alu_result, link;

  assign is_alu = exu_info_i[2:0] == rv_core_pkg::EXU_GRP_ALU;
  assign is_bjp = exu_info_i[2:0] == rv_core_pkg::EXU_GRP_BJP;

  // Op bits overlap between groups, so each unit only sees its own
  assign alu_info = {rv_core_pkg::EXU_INFO_W{is_alu}} & exu_info_i;
  assign bjp_info = {rv_core_pkg::EXU_INFO_W{is_bjp}} & exu_info_i;

  rv_alu u_rv_alu (
    .info_i   (alu_info),
    .op1_i    (op1_i),
    .op2_i    (op2_i),
    .result_o (alu_result)
  );

  rv_bju u_rv_bju (
    .info_i   (bjp_info),
    .rs1_i    (rs1_data_i),
    .rs2_i    (rs2_data_i),
    .op1_jp_i (op1_jp_i),
    .op2_jp_i (op2_jp_i),
    .taken_o  (bju_taken),
    .target_o (target_o)
  );

  // Link value PC+4 for JAL and JALR
  assign link = op1_i + op2_i;

  assign wb_data_o = is_bjp ? link : alu_result;
  assign taken_o   = is_bjp & bju_taken;
  assign ebreak_o  = alu_info[rv_core_pkg::EXU_ALU_EBREAK];

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n_i,
  input  wire logic                      inst_valid_i,
  input  wire logic [31:0]               inst_i,
  output logic                           retire_valid_o,
  output logic                           rd_wr_en_o,
  output logic [4:0]                     rd_idx_o,
  output logic [rv_core_pkg::XLEN-1:0]   rd_data_o,
  output logic [rv_core_pkg::XLEN-1:0]   next_pc_o,
  output logic                           invalid_o,
  output logic                           ebreak_o
);

  logic [rv_core_pkg::XLEN-1:0] pc_q, pc_next, pc_plus4;
  logic [rv_core_pkg::XLEN-1:0] rs1_data, rs2_data, op1, op2, op1_jp, op2_jp;
  logic [rv_core_pkg::XLEN-1:0] wb_data, target;
  logic [rv_core_pkg::EXU_INFO_W-1:0] exu_info;
  logic [4:0] rs1_idx, rs2_idx, rd_idx;
  logic rd_wr_en, invalid, taken, ebreak, rf_wr_en;

  assign pc_plus4 = pc_q + 64'd4;
  assign pc_next  = taken ? target : pc_plus4;
  assign rf_wr_en = inst_valid_i & rd_wr_en & ~invalid;

  rv_idu u_rv_idu (
    .inst_i         (inst_i),
    .pc_i           (pc_q),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .rd_wr_en_o     (rd_wr_en),
    .rs1_idx_o      (rs1_idx),
    .rs2_idx_o      (rs2_idx),
    .rd_idx_o       (rd_idx),
    .op1_o          (op1),
    .op2_o          (op2),
    .op1_jp_o       (op1_jp),
    .op2_jp_o       (op2_jp),
    .exu_info_bus_o (exu_info),
    .invalid_inst_o (invalid)
  );

  rv_regfile u_rv_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_en_i    (rf_wr_en),
    .wr_idx_i   (rd_idx),
    .wr_data_i  (wb_data)
  );

  rv_exu u_rv_exu (
    .exu_info_i (exu_info),
    .op1_i      (op1),
    .op2_i      (op2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .op1_jp_i   (op1_jp),
    .op2_jp_i   (op2_jp),
    .wb_data_o  (wb_data),
    .taken_o    (taken),
    .target_o   (target),
    .ebreak_o   (ebreak)
  );

  // PC advances only on a sampled instruction
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (inst_valid_i) begin
      pc_q <= pc_next;
    end
  end

  // Retire record, flags cleared on idle cycles
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
      rd_wr_en_o     <= 1'b0;
      invalid_o      <= 1'b0;
      ebreak_o       <= 1'b0;
      rd_idx_o       <= '0;
      rd_data_o      <= '0;
      next_pc_o      <= '0;
    end else begin
      retire_valid_o <= inst_valid_i;
      rd_wr_en_o     <= rf_wr_en;
      invalid_o      <= inst_valid_i & invalid;
      ebreak_o       <= inst_valid_i & ebreak;
      if (inst_valid_i) begin
        rd_idx_o  <= rd_idx;
        rd_data_o <= wb_data;
        next_pc_o <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
  input wire logic                          clk,
  input wire logic                          rst_n_i,
  input wire logic                          retire_valid_i,
  input wire logic                          rd_wr_en_i,
  input wire logic [4:0]                    rd_idx_i,
  input wire logic                          invalid_i,
  input wire logic [rv_core_pkg::XLEN-1:0]  next_pc_i
);

  // Failure count, read by the testbench
  int fail_cnt = 0;

  // Retire register comes out of reset empty
  a_no_retire_in_reset: assert property (@(posedge clk) !rst_n_i |=> !retire_valid_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("retire_valid_o high after a reset cycle");
    end

  a_invalid_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    (retire_valid_i && invalid_i) |-> !rd_wr_en_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("invalid instruction retired with a register write");
    end

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_wr_en_i |-> (rd_idx_i != 5'd0))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("register write reported for x0");
    end

  // No compressed support, so every PC is word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    retire_valid_i |-> (next_pc_i[1:0] == 2'b00))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("next_pc_o not 4-aligned");
    end

endmodule

bind rv_core_top rv_core_props u_rv_core_props (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .retire_valid_i (retire_valid_o),
  .rd_wr_en_i     (rd_wr_en_o),
  .rd_idx_i       (rd_idx_o),
  .invalid_i      (invalid_o),
  .next_pc_i      (next_pc_o)
);

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int N_SETUP = 31;
  localparam int N_ALU   = 200;
  localparam int N_BR    = 40;
  localparam int N_JMP   = 10;
  localparam int N_BAD   = 20;
  localparam int N_DEP   = 40;
  // Fixed extras are 3 branch operands, 18 directed branches, 1 JALR base and 3 EBREAK
  localparam int N_INST = N_SETUP + N_ALU + 3 + 18 + N_BR + 1 + 2 * N_JMP + N_BAD + 3 + N_DEP;
  localparam int CYCLE_LIMIT = 4 * N_INST + 100;

  typedef struct packed {
    logic        wr_en;
    logic [4:0]  idx;
    logic [63:0] data;
    logic [63:0] next_pc;
    logic        invalid;
    logic        ebreak;
  } retire_t;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        retire_valid_o, rd_wr_en_o, invalid_o, ebreak_o;
  logic [4:0]  rd_idx_o;
  logic [63:0] rd_data_o, next_pc_o;

  integer      seed;
  int          errors = 0;
  int          issued = 0;
  int          retired = 0;
  int          cycles = 0;
  int          afails;
  logic [63:0] model_regs [32];
  logic [63:0] model_pc;
  retire_t     exp_q [$];
  retire_t     want;
  logic [31:0] r;
  logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  rv_core_top u_rv_core_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .retire_valid_o (retire_valid_o),
    .rd_wr_en_o     (rd_wr_en_o),
    .rd_idx_o       (rd_idx_o),
    .rd_data_o      (rd_data_o),
    .next_pc_o      (next_pc_o),
    .invalid_o      (invalid_o),
    .ebreak_o       (ebreak_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
  endfunction

  // ISA model of one retire that also updates model_regs and model_pc
  function automatic retire_t rv_ref_step(input logic [31:0] inst);
    retire_t     rec;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [63:0] a, b, imm_i, imm_b, imm_u, imm_j, res, tgt, pc4;
    logic        valid, wr, take;
    rd    = inst[11:7];
    f3    = inst[14:12];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    pc4   = model_pc + 64'd4;
    rec   = '0;
    res   = '0;
    tgt   = '0;
    valid = 1'b1;
    wr    = 1'b1;
    take  = 1'b0;
    case (inst[6:0])
      rv_core_pkg::OPC_OP: begin
        case ({inst[31:25], f3})
          {7'h00, 3'd0}: res = a + b;
          {7'h20, 3'd0}: res = a - b;
          {7'h00, 3'd1}: res = a << b[5:0];
          {7'h00, 3'd2}: res = {63'd0, $signed(a) < $signed(b)};
          {7'h00, 3'd3}: res = {63'd0, a < b};
          {7'h00, 3'd4}: res = a ^ b;
          {7'h00, 3'd5}: res = a >> b[5:0];
          {7'h20, 3'd5}: res = $signed(a) >>> b[5:0];
          {7'h00, 3'd6}: res = a | b;
          {7'h00, 3'd7}: res = a & b;
          default: valid = 1'b0;
        endcase
      end
      rv_core_pkg::OPC_OP_IMM: begin
        case (f3)
          3'd0: res = a + imm_i;
          3'd2: res = {63'd0, $signed(a) < $signed(imm_i)};
          3'd3: res = {63'd0, a < imm_i};
          3'd4: res = a ^ imm_i;
          3'd6: res = a | imm_i;
          3'd7: res = a & imm_i;
          3'd1: begin
            if (inst[31:26] == 6'h00) res = a << inst[25:20];
            else valid = 1'b0;
          end
          default: begin
            if (inst[31:26] == 6'h00) res = a >> inst[25:20];
            else if (inst[31:26] == 6'h10) res = $signed(a) >>> inst[25:20];
            else valid = 1'b0;
          end
        endcase
      end
      rv_core_pkg::OPC_LUI:   res = imm_u;
      rv_core_pkg::OPC_AUIPC: res = model_pc + imm_u;
      rv_core_pkg::OPC_JAL: begin
        res  = pc4;
        take = 1'b1;
        tgt  = model_pc + imm_j;
      end
      rv_core_pkg::OPC_JALR: begin
        valid = (f3 == 3'd0);
        res   = pc4;
        take  = 1'b1;
        tgt   = (a + imm_i) & ~64'd1;
      end
      rv_core_pkg::OPC_BRANCH: begin
        wr  = 1'b0;
        tgt = model_pc + imm_b;
        case (f3)
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = $signed(a) < $signed(b);
          3'd5: take = $signed(a) >= $signed(b);
          3'd6: take = a < b;
          3'd7: take = a >= b;
          default: valid = 1'b0;
        endcase
      end
      rv_core_pkg::OPC_SYSTEM: begin
        wr = 1'b0;
        valid = (inst == 32'h0010_0073);
        rec.ebreak = valid;
      end
      default: valid = 1'b0;
    endcase
    rec.invalid = !valid;
    rec.wr_en   = valid && wr && (rd != 5'd0);
    rec.idx     = rd;
    rec.data    = res;
    rec.next_pc = (valid && take) ? tgt : pc4;
    if (rec.wr_en) model_regs[rd] = res;
    model_pc = rec.next_pc;
    return rec;
  endfunction

  task automatic issue(input logic [31:0] inst);
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    exp_q.push_back(rv_ref_step(inst));
    issued++;
  endtask

  // Garbage on inst_i while idle must be ignored
  task automatic idle();
    @(posedge clk);
    inst_valid_i <= 1'b0;
    inst_i       <= rand32();
  endtask

  // Compare on the falling edge away from the driving edge
  always @(negedge clk) begin
    if (rst_n_i && retire_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("error at %0t: retire with no instruction pending", $time);
      end else begin
        want = exp_q.pop_front();
        retired++;
        if (rd_wr_en_o !== want.wr_en) begin
          errors++;
          $display("error at %0t: rd_wr_en_o %b, expected %b", $time, rd_wr_en_o, want.wr_en);
        end
        if (want.wr_en && (rd_idx_o !== want.idx || rd_data_o !== want.data)) begin
          errors++;
          $display("error at %0t: write x%0d=%h, expected x%0d=%h", $time,
                   rd_idx_o, rd_data_o, want.idx, want.data);
        end
        if (next_pc_o !== want.next_pc) begin
          errors++;
          $display("error at %0t: next_pc_o %h, expected %h", $time, next_pc_o, want.next_pc);
        end
        if (invalid_o !== want.invalid || ebreak_o !== want.ebreak) begin
          errors++;
          $display("error at %0t: invalid/ebreak %b%b, expected %b%b", $time,
                   invalid_o, ebreak_o, want.invalid, want.ebreak);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles, %0d retires missing",
               CYCLE_LIMIT, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed         = 32'h5ca5d22a;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    model_pc     = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;

    // Register setup through ADDI, LUI and AUIPC
    for (int i = 1; i <= N_SETUP; i++) begin
      r = rand32();
      case (i % 3)
        0: issue(i_type(r[11:0], 5'd0, 3'd0, i[4:0], rv_core_pkg::OPC_OP_IMM));
        1: issue(u_type(r[19:0], i[4:0], rv_core_pkg::OPC_LUI));
        default: issue(u_type(r[19:0], i[4:0], rv_core_pkg::OPC_AUIPC));
      endcase
    end

    // Random ALU operations with x0 among the destinations
    repeat (N_ALU) begin
      r = rand32();
      if (r[0]) begin
        issue(r_type(r[30] ? 7'h20 : 7'h00, r[24:20], r[19:15], r[14:12], r[11:7]));
      end else begin
        if (r[13:12] == 2'b01) r[31:26] = r[30] ? 6'h10 : 6'h00;
        issue(i_type(r[31:20], r[19:15], r[14:12], r[11:7], rv_core_pkg::OPC_OP_IMM));
      end
    end

    // Branch operands with x5 negative and x6 equal to x7
    issue(i_type(12'hffb, 5'd0, 3'd0, 5'd5, rv_core_pkg::OPC_OP_IMM));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd6, rv_core_pkg::OPC_OP_IMM));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd7, rv_core_pkg::OPC_OP_IMM));
    for (int k = 0; k < 6; k++) begin
      r = rand32();
      issue(b_type(r[12:0] & 13'h1ffc, 5'd6, 5'd5, br_f3[k]));
      r = rand32();
      issue(b_type(r[12:0] & 13'h1ffc, 5'd5, 5'd6, br_f3[k]));
      r = rand32();
      issue(b_type(r[12:0] & 13'h1ffc, 5'd7, 5'd6, br_f3[k]));
    end
    repeat (N_BR) begin
      r = rand32();
      issue(b_type(r[12:0] & 13'h1ffc, r[24:20], r[19:15], br_f3[r[31:29] % 6]));
    end

    // Jumps through an odd base in x9 so JALR clears bit 0
    repeat (N_JMP) begin
      r = rand32();
      issue(j_type(r[20:0] & 21'h1ffffc, r[31:27]));
    end
    issue(i_type(12'h101, 5'd0, 3'd0, 5'd9, rv_core_pkg::OPC_OP_IMM));
    repeat (N_JMP) begin
      r = rand32();
      if (r[31:27] == 5'd9) r[31:27] = 5'd1;
      issue(i_type(r[11:0] & 12'hffc, 5'd9, 3'd0, r[31:27], rv_core_pkg::OPC_JALR));
    end

    // Loads, stores, unknown opcodes and EBREAK
    repeat (5) begin
      r = rand32();
      issue(i_type(r[11:0], r[19:15], 3'd3, r[24:20] | 5'd1, rv_core_pkg::OPC_LOAD));
      issue(s_type(r[11:0], r[24:20], r[19:15], 3'd3));
    end
    issue(32'h0010_0073);
    repeat (N_BAD - 10) begin
      r = rand32();
      issue({r[31:2], 2'b00});
    end
    issue(32'h0010_0073);
    issue(32'h0010_0073);

    // Dependent chain on x10/x11 with idle gaps
    for (int k = 0; k < N_DEP; k++) begin
      r = rand32();
      if (r[1:0] == 2'b00) idle();
      if (k % 2 == 0) issue(i_type(r[31:20], 5'd10, 3'd0, 5'd10, rv_core_pkg::OPC_OP_IMM));
      else issue(r_type(7'h00, 5'd10, 5'd11, 3'd0, 5'd11));
    end
    idle();

    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    if (retired != issued) begin
      errors++;
      $display("Retire count %0d does not match %0d issued instructions", retired, issued);
    end
    afails = u_rv_core_top.u_rv_core_props.fail_cnt;
    $display("Summary: %0d issued, %0d retired, %0d errors, %0d assertion failures",
             issued, retired, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/rv_core_pkg.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_bju.sv
hdl/rv_exu.sv
hdl/rv_core_top.sv
sim/rv_core_props.sv
sim/tb_rv_core.sv
